//--- src/lapipe_consts.svh
`ifndef LAPIPE_CONSTS_SVH
`define LAPIPE_CONSTS_SVH

// Datapath width
`define LAPIPE_XLEN 32

// Architectural registers, r0 hardwired to zero
`define LAPIPE_NREG 32

// Issue queue entries and producer credits after reset
`define LAPIPE_IQ_DEPTH 4

`endif

//--- src/lapipe_pkg.sv
`include "lapipe_consts.svh"

package lapipe_pkg;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_ADDI,   // imm replaces rk
        OP_MUL     // Lane 1 only
    } op_e;

    typedef logic [$clog2(`LAPIPE_NREG)-1:0] reg_idx_t;
    typedef logic [`LAPIPE_XLEN-1:0]         xlen_t;

    typedef struct packed {
        op_e      op;
        reg_idx_t rj;
        reg_idx_t rk;
        reg_idx_t rd;
        xlen_t    imm;
        logic     valid;
    } uop_t;

    typedef struct packed {
        uop_t lane1;
        uop_t lane0;
    } uop_pair_t;

endpackage

//--- src/bypass_if.sv
`timescale 1ns/100ps

// One stage register as seen by forwarding and write-back
interface bypass_if;
    import lapipe_pkg::*;

    reg_idx_t [2:0] tag;     // Zero when the slot carries nothing
    logic     [2:0] ready;   // Value may be forwarded
    xlen_t    [2:0] data;

    modport source (
        output tag,
        output ready,
        output data
    );

    modport sink (
        input tag,
        input ready,
        input data
    );

endinterface

//--- src/issue_queue.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module issue_queue (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  lapipe_pkg::uop_pair_t pair_i,
    input  logic                  pop_i,
    output lapipe_pkg::uop_pair_t head_o,
    output logic                  head_valid_o,
    output logic                  credit_o
);
    import lapipe_pkg::*;

    localparam int DEPTH = `LAPIPE_IQ_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    uop_pair_t     mem [DEPTH];
    logic [PW-1:0] head_q;
    logic [PW-1:0] tail_q;
    logic [PW:0]   count_q;
    logic          full;
    logic          do_push;
    logic          do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full         = (count_q == (PW+1)'(DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[head_q];

    assign do_push = push_i && !full;     // Full push is a producer bug
    assign do_pop  = pop_i && head_valid_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (do_push)
                tail_q <= next_ptr(tail_q);
            if (do_pop)
                head_q <= next_ptr(head_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            credit_o <= do_pop;           // One credit back per popped pair
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push)
            mem[tail_q] <= pair_i;
    end

endmodule

//--- src/ex1_forward.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module ex1_forward (
    input  lapipe_pkg::reg_idx_t    rj_i,
    input  lapipe_pkg::reg_idx_t    rk_i,
    input  logic [`LAPIPE_XLEN-1:0] rj_data_i,
    input  logic [`LAPIPE_XLEN-1:0] rk_data_i,
    bypass_if.sink                  ex1_ex2,
    bypass_if.sink                  ex2_wb,
    output logic [`LAPIPE_XLEN-1:0] rj_data_o,
    output logic [`LAPIPE_XLEN-1:0] rk_data_o,
    output logic                    stall_o
);
    import lapipe_pkg::*;

    localparam int NSRC = 5;

    reg_idx_t src_tag  [NSRC];
    logic     src_rdy  [NSRC];
    xlen_t    src_data [NSRC];
    logic     rj_stall;
    logic     rk_stall;

    // Candidates in priority order, youngest first
    always_comb begin
        src_tag[0]  = ex1_ex2.tag[1];
        src_rdy[0]  = ex1_ex2.ready[1];
        src_data[0] = ex1_ex2.data[1];
        src_tag[1]  = ex1_ex2.tag[0];
        src_rdy[1]  = ex1_ex2.ready[0];
        src_data[1] = ex1_ex2.data[0];
        src_tag[2]  = ex2_wb.tag[1];
        src_rdy[2]  = ex2_wb.ready[1];
        src_data[2] = ex2_wb.data[1];
        src_tag[3]  = ex2_wb.tag[0];
        src_rdy[3]  = ex2_wb.ready[0];
        src_data[3] = ex2_wb.data[0];
        src_tag[4]  = ex2_wb.tag[2];      // MUL result
        src_rdy[4]  = ex2_wb.ready[2];
        src_data[4] = ex2_wb.data[2];
    end

    function automatic void pick(
        input  reg_idx_t src,
        input  xlen_t    rf_val,
        output xlen_t    val,
        output logic     stall
    );
        logic hit;
        hit   = 1'b0;
        val   = rf_val;
        stall = 1'b0;
        for (int i = 0; i < NSRC; i++) begin
            // r0 never matches, its tag also marks an empty slot
            if (!hit && src != '0 && src == src_tag[i]) begin
                hit   = 1'b1;
                val   = src_data[i];
                stall = !src_rdy[i];      // Producer still computing
            end
        end
    endfunction

    always_comb begin
        pick(rj_i, rj_data_i, rj_data_o, rj_stall);
    end

    always_comb begin
        pick(rk_i, rk_data_i, rk_data_o, rk_stall);
    end

    assign stall_o = rj_stall || rk_stall;

endmodule

//--- src/ex1_stage.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module ex1_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  lapipe_pkg::uop_pair_t         head_i,
    input  logic                          head_valid_i,
    output logic                          pop_o,
    output lapipe_pkg::reg_idx_t [3:0]    rd_addr_o,
    input  logic [3:0][`LAPIPE_XLEN-1:0]  rd_data_i,
    bypass_if.source                      ex1_ex2,
    bypass_if.sink                        ex2_wb,
    output logic [`LAPIPE_XLEN-1:0]       mul_lo_o,
    output logic [`LAPIPE_XLEN-1:0]       mul_hi_o,
    output lapipe_pkg::reg_idx_t          mul_rd_o
);
    import lapipe_pkg::*;

    localparam int H = `LAPIPE_XLEN / 2;

    uop_pair_t ex1_q;
    reg_idx_t  rk0_src;
    reg_idx_t  rk1_src;
    reg_idx_t  tag0_n;
    reg_idx_t  tag1_n;
    xlen_t     a0, b0, a1, b1;
    logic      st0, st1;
    logic      stall;
    logic      l1_mul;

    bypass_if ex1_ex2_fb ();              // Read-back of our own EX1/EX2 register

    function automatic xlen_t alu(input uop_t u, input xlen_t a, input xlen_t b);
        case (u.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_ADDI: return a + u.imm;
            default: return '0;           // MUL completes in EX2
        endcase
    endfunction

    assign rd_addr_o = {ex1_q.lane1.rk, ex1_q.lane1.rj, ex1_q.lane0.rk, ex1_q.lane0.rj};
    assign rk0_src   = (ex1_q.lane0.op == OP_ADDI) ? '0 : ex1_q.lane0.rk;
    assign rk1_src   = (ex1_q.lane1.op == OP_ADDI) ? '0 : ex1_q.lane1.rk;

    assign ex1_ex2_fb.tag   = ex1_ex2.tag;
    assign ex1_ex2_fb.ready = ex1_ex2.ready;
    assign ex1_ex2_fb.data  = ex1_ex2.data;

    ex1_forward i_fwd0 (
        .rj_i(ex1_q.lane0.rj), .rk_i(rk0_src),
        .rj_data_i(rd_data_i[0]), .rk_data_i(rd_data_i[1]),
        .ex1_ex2(ex1_ex2_fb), .ex2_wb(ex2_wb),
        .rj_data_o(a0), .rk_data_o(b0), .stall_o(st0)
    );

    ex1_forward i_fwd1 (
        .rj_i(ex1_q.lane1.rj), .rk_i(rk1_src),
        .rj_data_i(rd_data_i[2]), .rk_data_i(rd_data_i[3]),
        .ex1_ex2(ex1_ex2_fb), .ex2_wb(ex2_wb),
        .rj_data_o(a1), .rk_data_o(b1), .stall_o(st1)
    );

    assign stall  = (ex1_q.lane0.valid && st0) || (ex1_q.lane1.valid && st1);
    assign pop_o  = head_valid_i && !stall;
    assign l1_mul = ex1_q.lane1.valid && (ex1_q.lane1.op == OP_MUL);
    assign tag0_n = (ex1_q.lane0.valid && !stall) ? ex1_q.lane0.rd : '0;
    assign tag1_n = (ex1_q.lane1.valid && !stall) ? ex1_q.lane1.rd : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex1_q         <= '0;
            ex1_ex2.tag   <= '0;
            ex1_ex2.ready <= '0;
            mul_rd_o      <= '0;
        end else begin
            if (!stall)
                ex1_q <= pop_o ? head_i : '0;     // Hold the pair on stall
            ex1_ex2.tag   <= {reg_idx_t'(0), tag1_n, tag0_n};
            ex1_ex2.ready <= {1'b0, !l1_mul, 1'b1};
            mul_rd_o      <= (l1_mul && !stall) ? ex1_q.lane1.rd : '0;
        end
    end

    // Low product bits only, cross terms folded into one partial
    always_ff @(posedge clk_i) begin
        ex1_ex2.data <= {xlen_t'(0), alu(ex1_q.lane1, a1, b1), alu(ex1_q.lane0, a0, b0)};
        mul_lo_o     <= a1[H-1:0] * b1[H-1:0];
        mul_hi_o     <= a1[`LAPIPE_XLEN-1:H] * b1[H-1:0] + a1[H-1:0] * b1[`LAPIPE_XLEN-1:H];
    end

endmodule

//--- src/ex2_stage.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module ex2_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    bypass_if.sink                  ex1_ex2,
    input  logic [`LAPIPE_XLEN-1:0] mul_lo_i,
    input  logic [`LAPIPE_XLEN-1:0] mul_hi_i,
    input  lapipe_pkg::reg_idx_t    mul_rd_i,
    bypass_if.source                ex2_wb
);
    import lapipe_pkg::*;

    localparam int H = `LAPIPE_XLEN / 2;

    xlen_t    mul_res;
    reg_idx_t slot1_tag;

    // Only the low half of the cross partial reaches the low word
    assign mul_res = mul_lo_i + {mul_hi_i[H-1:0], {H{1'b0}}};

    // Lane 1 ALU slot is empty when lane 1 was a MUL
    assign slot1_tag = ex1_ex2.ready[1] ? ex1_ex2.tag[1] : '0;

    assign ex2_wb.ready = 3'b111;         // Everything here is final

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex2_wb.tag <= '0;
        end else begin
            ex2_wb.tag <= {mul_rd_i, slot1_tag, ex1_ex2.tag[0]};
        end
    end

    always_ff @(posedge clk_i) begin
        ex2_wb.data <= {mul_res, ex1_ex2.data[1], ex1_ex2.data[0]};
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module regfile (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  lapipe_pkg::reg_idx_t [3:0]   rd_addr_i,
    output logic [3:0][`LAPIPE_XLEN-1:0] rd_data_o,
    bypass_if.sink                       wr
);
    import lapipe_pkg::*;

    xlen_t regs [`LAPIPE_NREG];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `LAPIPE_NREG; i++)
                regs[i] <= '0;
        end else begin
            // Later slot wins, r0 tag means no write
            for (int s = 0; s < 3; s++) begin
                if (wr.ready[s] && wr.tag[s] != '0)
                    regs[wr.tag[s]] <= wr.data[s];
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++)
            rd_data_o[p] = (rd_addr_i[p] == '0) ? '0 : regs[rd_addr_i[p]];
    end

endmodule

//--- src/lapipe_top.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module lapipe_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         issue_valid_i,
    input  lapipe_pkg::uop_pair_t        issue_pair_i,
    output logic                         credit_o,
    output logic [2:0]                   wb_we_o,
    output lapipe_pkg::reg_idx_t [2:0]   wb_rd_o,
    output logic [2:0][`LAPIPE_XLEN-1:0] wb_data_o
);
    import lapipe_pkg::*;

    uop_pair_t       head;
    logic            head_valid;
    logic            pop;
    reg_idx_t  [3:0] rd_addr;
    xlen_t     [3:0] rd_data;
    xlen_t           mul_lo;
    xlen_t           mul_hi;
    reg_idx_t        mul_rd;

    bypass_if ex1_ex2 ();
    bypass_if ex2_wb ();

    issue_queue i_issue_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (issue_valid_i),
        .pair_i       (issue_pair_i),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .credit_o     (credit_o)
    );

    ex1_stage i_ex1_stage (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .head_i       (head),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data),
        .ex1_ex2      (ex1_ex2),
        .ex2_wb       (ex2_wb),
        .mul_lo_o     (mul_lo),
        .mul_hi_o     (mul_hi),
        .mul_rd_o     (mul_rd)
    );

    ex2_stage i_ex2_stage (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ex1_ex2  (ex1_ex2),
        .mul_lo_i (mul_lo),
        .mul_hi_i (mul_hi),
        .mul_rd_i (mul_rd),
        .ex2_wb   (ex2_wb)
    );

    regfile i_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .wr        (ex2_wb)
    );

    // Write-back view, same condition the register file uses
    always_comb begin
        for (int i = 0; i < 3; i++)
            wb_we_o[i] = ex2_wb.ready[i] && (ex2_wb.tag[i] != '0);
    end

    assign wb_rd_o   = ex2_wb.tag;
    assign wb_data_o = ex2_wb.data;

endmodule

//--- sim/lapipe_properties.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module lapipe_properties (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  issue_valid_i,
    input lapipe_pkg::uop_pair_t issue_pair_i,
    input logic                  pop_i,
    input logic                  credit_i,
    input logic [2:0]            wb_we_i
);
    import lapipe_pkg::*;

    int   outstanding;   // Pairs pushed whose credit has not come back
    int   occupancy;
    int   failures;      // Assertion failures so far
    logic pushed_any;

    initial failures = 0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding <= 0;
            occupancy   <= 0;
            pushed_any  <= 1'b0;
        end else begin
            outstanding <= outstanding + (issue_valid_i ? 1 : 0) - (credit_i ? 1 : 0);
            occupancy   <= occupancy + (issue_valid_i ? 1 : 0) - (pop_i ? 1 : 0);
            if (issue_valid_i)
                pushed_any <= 1'b1;
        end
    end

    // Lane 1 may not read or overwrite lane 0's destination
    function automatic logic dep_free(input uop_pair_t p);
        if (!p.lane0.valid || !p.lane1.valid || p.lane0.rd == '0)
            return 1'b1;
        return p.lane1.rj != p.lane0.rd && p.lane1.rd != p.lane0.rd
            && (p.lane1.op == OP_ADDI || p.lane1.rk != p.lane0.rd);
    endfunction

    a_credit_after_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_i |-> outstanding > 0)
    else begin
        failures++;
        $error("Credit returned without a pushed pair");
    end

    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        outstanding <= `LAPIPE_IQ_DEPTH)
    else begin
        failures++;
        $error("More credits out than queue entries");
    end

    a_no_full_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_i |-> occupancy < `LAPIPE_IQ_DEPTH)
    else begin
        failures++;
        $error("Push into a full queue");
    end

    a_no_pair_dep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_i |-> dep_free(issue_pair_i))
    else begin
        failures++;
        $error("Dependency inside a pair");
    end

    a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !pushed_any |-> !credit_i && wb_we_i == '0)
    else begin
        failures++;
        $error("Activity before first push");
    end

endmodule

bind lapipe_top lapipe_properties i_lapipe_properties (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_pair_i  (issue_pair_i),
    .pop_i         (pop),
    .credit_i      (credit_o),
    .wb_we_i       (wb_we_o)
);

//--- sim/lapipe_tb.sv
`timescale 1ns/100ps
`include "lapipe_consts.svh"

module lapipe_tb;
    import lapipe_pkg::*;

    localparam int TIMEOUT = 100;

    logic                         clk_i;
    logic                         rst_n_i;
    logic                         issue_valid_i;
    uop_pair_t                    issue_pair_i;
    logic                         credit_o;
    logic [2:0]                   wb_we_o;
    reg_idx_t [2:0]               wb_rd_o;
    logic [2:0][`LAPIPE_XLEN-1:0] wb_data_o;

    integer                  seed;
    int                      credits;
    int                      checked;
    int                      mismatches;
    int                      other_errors;
    int                      assert_failures;
    logic                    hung;
    string                   test_name;
    xlen_t                   ref_regs [`LAPIPE_NREG];  // Register state in program order
    logic [`LAPIPE_XLEN+4:0] exp_q [$];                // {rd, data} in write-back order

    lapipe_top i_lapipe_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic xlen_t model_result(input uop_t u, input xlen_t a, input xlen_t b);
        case (u.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_ADDI: return a + u.imm;
            default: return a * b;            // MUL keeps the low word
        endcase
    endfunction

    function automatic uop_t random_uop(input int mask);
        uop_t u;
        u.op    = op_e'(3'($random(seed)));
        u.rj    = reg_idx_t'($random(seed) & mask);
        u.rk    = reg_idx_t'($random(seed) & mask);
        u.rd    = reg_idx_t'($random(seed) & mask);
        u.imm   = $random(seed);
        u.valid = ($random(seed) & 7) != 0;   // Some empty lanes
        return u;
    endfunction

    function automatic uop_pair_t make_pair(input int mask);
        uop_pair_t p;
        p.lane0    = random_uop(mask);
        p.lane1    = random_uop(mask);
        p.lane0.op = (p.lane0.op == OP_MUL) ? OP_ADDI : p.lane0.op;
        // Clashes with lane 0 fall back to r0
        if (p.lane0.rd != '0) begin
            p.lane1.rj = (p.lane1.rj == p.lane0.rd) ? '0 : p.lane1.rj;
            p.lane1.rk = (p.lane1.rk == p.lane0.rd) ? '0 : p.lane1.rk;
            p.lane1.rd = (p.lane1.rd == p.lane0.rd) ? '0 : p.lane1.rd;
        end
        return p;
    endfunction

    task automatic predict(input uop_pair_t p);
        xlen_t res0;
        xlen_t res1;
        res0 = model_result(p.lane0, ref_regs[p.lane0.rj], ref_regs[p.lane0.rk]);
        res1 = model_result(p.lane1, ref_regs[p.lane1.rj], ref_regs[p.lane1.rk]);
        if (p.lane0.valid && p.lane0.rd != '0) begin
            exp_q.push_back({p.lane0.rd, res0});
            ref_regs[p.lane0.rd] = res0;
        end
        if (p.lane1.valid && p.lane1.rd != '0) begin
            exp_q.push_back({p.lane1.rd, res1});
            ref_regs[p.lane1.rd] = res1;
        end
    endtask

    // Advance one falling edge and look at credits and write-backs there
    task automatic next_cycle();
        logic [`LAPIPE_XLEN+4:0] want;
        @(negedge clk_i);
        if (credit_o)
            credits++;
        for (int i = 0; i < 3; i++) begin
            if (wb_we_o[i] && exp_q.size() == 0) begin
                other_errors++;
                $display("Write-back to r%0d with no instruction outstanding", wb_rd_o[i]);
            end else if (wb_we_o[i]) begin
                want = exp_q.pop_front();
                checked++;
                assert ({wb_rd_o[i], wb_data_o[i]} == want) else begin
                    mismatches++;
                    $display("Error %s: expected r%0d = %h, actual r%0d = %h", test_name,
                             want[`LAPIPE_XLEN+:5], want[`LAPIPE_XLEN-1:0],
                             wb_rd_o[i], wb_data_o[i]);
                end
            end
        end
    endtask

    task automatic send_pair(input uop_pair_t p);
        int waited;
        waited        = 0;
        issue_valid_i = 1'b0;
        while (credits == 0 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (credits == 0) begin
            hung = 1'b1;
            other_errors++;
            $display("Pipeline hung: no credit came back for %0d cycles", TIMEOUT);
        end else begin
            issue_pair_i  = p;
            issue_valid_i = 1'b1;
            credits--;
            predict(p);
            next_cycle();
        end
    endtask

    task automatic run_phase(input string name, input int mask, input int pairs);
        int waited;
        test_name = name;
        for (int n = 0; n < pairs && !hung; n++)
            send_pair(make_pair(mask));
        issue_valid_i = 1'b0;
        waited        = 0;
        while (!hung && exp_q.size() != 0 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!hung && exp_q.size() != 0) begin
            hung = 1'b1;
            other_errors++;
            $display("Pipeline hung: %0d write-backs never arrived in %s", exp_q.size(), name);
        end
    endtask

    initial begin
        seed            = 32'h2258;
        rst_n_i         = 1'b0;
        issue_valid_i   = 1'b0;
        issue_pair_i    = '0;
        credits         = `LAPIPE_IQ_DEPTH;
        checked         = 0;
        mismatches      = 0;
        other_errors    = 0;
        assert_failures = 0;
        hung            = 1'b0;
        test_name       = "reset";
        foreach (ref_regs[r])
            ref_regs[r] = '0;
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;
        run_phase("sparse_regs", 31, 120);
        run_phase("dense_regs", 7, 200);   // Few registers give many forwards and MUL stalls
        assert_failures = i_lapipe_top.i_lapipe_properties.failures;
        $display("Summary: %0d checked, %0d mismatches, %0d other errors, %0d assert failures",
                 checked, mismatches, other_errors, assert_failures);
        if (mismatches == 0 && other_errors == 0 && assert_failures == 0 && checked > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- lapipe.f
+incdir+src
src/lapipe_pkg.sv
src/bypass_if.sv
src/issue_queue.sv
src/ex1_forward.sv
src/ex1_stage.sv
src/ex2_stage.sv
src/regfile.sv
src/lapipe_top.sv
sim/lapipe_properties.sv
sim/lapipe_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := lapipe_tb
FILELIST  := lapipe.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
